/* logic/line_mem_pkg.sv */
package line_mem_pkg;

  // application port of the DDR controller, fixed by the controller build
  // 27-bit byte address into the DDR part
  localparam int app_addr_bits = 27;

  // one burst of the 4:1 controller
  // 16-bit DDR bus x 8 beats
  localparam int app_data_bits = 128;

  // address step from one burst to the next
  localparam int burst_bytes = app_data_bits / 8;

  // opcode of a queued line request
  typedef enum logic {
    op_write,
    op_read
  } req_op_e;

  // controller command codes
  // only write and read are issued here
  typedef enum logic [2:0] {
    app_cmd_write = 3'd0,
    app_cmd_read  = 3'd1
  } app_cmd_e;

  // dispatch FSM
  // idle: waiting on the queue
  // write_send: walking the bursts of a write line
  // read_send: issuing the read commands of a line
  // read_wait: handing the line over to gather
  typedef enum logic [1:0] {
    st_idle,
    st_write_send,
    st_read_send,
    st_read_wait
  } dispatch_state_e;

endpackage

/* logic/line_req_if.sv */
interface line_req_if
  import line_mem_pkg::*;
#(
  parameter int line_bytes = 64
);

  // handshake
  logic valid;
  logic ready;

  // payload, held while valid and not ready
  req_op_e op;
  logic [app_addr_bits-1:0] addr;
  // whole line, burst k sits at bits [128k+127 : 128k]
  logic [line_bytes*8-1:0] data;

  modport producer(output valid, output op, output addr, output data, input ready);

  modport consumer(input valid, input op, input addr, input data, output ready);

endinterface

/* logic/line_request_intake.sv */
module line_request_intake
  import line_mem_pkg::*;
#(
  parameter int line_bytes = 64
) (
  input  logic                     sclk,
  input  logic                     rst,
  input  logic                     wr_valid,
  output logic                     wr_ready,
  input  logic [app_addr_bits-1:0] wr_addr,
  input  logic [line_bytes*8-1:0]  wr_data,
  input  logic                     rd_valid,
  output logic                     rd_ready,
  input  logic [app_addr_bits-1:0] rd_addr,
  line_req_if.producer             req
);

  // read already offered and stalled, keep it on the bus
  logic rd_lock;
  logic sel_rd;

  // writes win a tie, unless the read was already presented
  assign sel_rd = rd_lock || (rd_valid && !wr_valid);

  assign req.valid = wr_valid || rd_valid;
  assign req.op    = sel_rd ? op_read : op_write;
  assign req.addr  = sel_rd ? rd_addr : wr_addr;
  // reads carry no data, zero keeps the payload steady
  assign req.data  = sel_rd ? '0 : wr_data;

  // zero-latency ready, straight from the queue side
  assign wr_ready = req.ready && !sel_rd;
  assign rd_ready = req.ready && sel_rd;

  always_ff @(posedge sclk) begin
    if (rst) begin
      rd_lock <= 1'b0;
    end else begin
      rd_lock <= sel_rd && rd_valid && !req.ready;
    end
  end

  // stalled request must not change under the queue
  a_req_stable : assert property (@(posedge sclk) disable iff (rst)
    req.valid && !req.ready |=> req.valid && $stable(req.op) && $stable(req.addr)
      && $stable(req.data));

endmodule

/* logic/line_request_queue.sv */
module line_request_queue
  import line_mem_pkg::*;
#(
  parameter int line_bytes  = 64,
  parameter int queue_depth = 4
) (
  input  logic         sclk,
  input  logic         rst,
  line_req_if.consumer push,
  line_req_if.producer pop
);

  localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int count_bits = $clog2(queue_depth + 1);

  // entry storage
  req_op_e                  op_mem   [queue_depth];
  logic [app_addr_bits-1:0] addr_mem [queue_depth];
  logic [line_bytes*8-1:0]  data_mem [queue_depth];

  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [count_bits-1:0] count;
  // low in reset and the clock after it
  logic                  live;
  logic                  push_fire;
  logic                  pop_fire;

  function automatic logic [ptr_bits-1:0] ptr_next(input logic [ptr_bits-1:0] p);
    return (p == ptr_bits'(queue_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push.ready = live && (count != count_bits'(queue_depth));
  assign push_fire  = push.valid && push.ready;

  // head entry straight out of the array
  assign pop.valid = (count != '0);
  assign pop.op    = op_mem[rd_ptr];
  assign pop.addr  = addr_mem[rd_ptr];
  assign pop.data  = data_mem[rd_ptr];
  assign pop_fire  = pop.valid && pop.ready;

  always_ff @(posedge sclk) begin
    if (rst) begin
      live   <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      live <= 1'b1;
      if (push_fire) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // push and pop together leave the count alone
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge sclk) begin
    if (push_fire) begin
      op_mem[wr_ptr]   <= push.op;
      addr_mem[wr_ptr] <= push.addr;
      data_mem[wr_ptr] <= push.data;
    end
  end

  // a push onto a full queue would land on the unread head entry
  a_no_push_full : assert property (@(posedge sclk) disable iff (rst)
    push_fire && pop.valid |-> wr_ptr != rd_ptr);

  // equal pointers with an entry shown only when every slot is taken
  a_no_valid_empty : assert property (@(posedge sclk) disable iff (rst)
    pop.valid && (wr_ptr == rd_ptr) |-> count == count_bits'(queue_depth));

endmodule

/* logic/burst_dispatch.sv */
module burst_dispatch
  import line_mem_pkg::*;
#(
  parameter int line_bytes = 64
) (
  input  logic                     sclk,
  input  logic                     rst,
  line_req_if.consumer             req,
  output logic                     app_en,
  output app_cmd_e                 app_cmd,
  output logic [app_addr_bits-1:0] app_addr,
  output logic                     app_wdf_wren,
  output logic                     app_wdf_end,
  output logic [app_data_bits-1:0] app_wdf_data,
  input  logic                     app_rdy,
  input  logic                     app_wdf_rdy,
  input  logic                     gather_busy,
  output logic                     gather_start
);

  localparam int num_bursts = line_bytes / burst_bytes;
  localparam int cnt_bits   = (num_bursts > 1) ? $clog2(num_bursts) : 1;
  localparam int line_lsb   = $clog2(line_bytes);

  dispatch_state_e state;

  logic [cnt_bits-1:0]     burst_cnt;
  logic [cnt_bits-1:0]     next_cnt;
  logic                    last;
  logic                    accept;
  logic                    burst_take;
  // copy of the line being walked
  logic [app_addr_bits-1:0] line_addr;
  logic [line_bytes*8-1:0]  line_data;

  // reads wait for gather to free its line register
  assign req.ready = (state == st_idle) && (req.op == op_write || !gather_busy);
  assign accept    = req.valid && req.ready;

  assign next_cnt = burst_cnt + 1'b1;
  assign last     = (burst_cnt == cnt_bits'(num_bursts - 1));

  // write burst needs both readies, read command only app_rdy
  assign burst_take = ((state == st_write_send) && app_rdy && app_wdf_rdy)
                   || ((state == st_read_send) && app_rdy);

  // first read command taken
  assign gather_start = (state == st_read_send) && app_rdy && (burst_cnt == '0);

  // control state
  always_ff @(posedge sclk) begin
    if (rst) begin
      state        <= st_idle;
      burst_cnt    <= '0;
      app_en       <= 1'b0;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            burst_cnt <= '0;
            app_en    <= 1'b1;
            if (req.op == op_write) begin
              // single-beat bursts, end goes with every wren
              app_wdf_wren <= 1'b1;
              app_wdf_end  <= 1'b1;
              state        <= st_write_send;
            end else begin
              state <= st_read_send;
            end
          end
        end
        st_write_send: begin
          if (burst_take) begin
            if (last) begin
              app_en       <= 1'b0;
              app_wdf_wren <= 1'b0;
              app_wdf_end  <= 1'b0;
              state        <= st_idle;
            end else begin
              burst_cnt <= next_cnt;
            end
          end
        end
        st_read_send: begin
          if (burst_take) begin
            if (last) begin
              app_en <= 1'b0;
              state  <= st_read_wait;
            end else begin
              burst_cnt <= next_cnt;
            end
          end
        end
        st_read_wait: begin
          // gather owns the line once busy shows, later writes may go
          if (gather_busy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command payload, held while app_en waits
  always_ff @(posedge sclk) begin
    if (accept) begin
      line_addr    <= req.addr;
      line_data    <= req.data;
      app_addr     <= req.addr;
      app_cmd      <= (req.op == op_write) ? app_cmd_write : app_cmd_read;
      app_wdf_data <= req.data[app_data_bits-1:0];
    end else if (burst_take && !last) begin
      // burst k at line address plus k bursts
      app_addr     <= line_addr + app_addr_bits'(next_cnt) * app_addr_bits'(burst_bytes);
      app_wdf_data <= line_data[next_cnt*app_data_bits +: app_data_bits];
    end
  end

  a_line_aligned : assert property (@(posedge sclk) disable iff (rst)
    accept |-> req.addr[line_lsb-1:0] == '0);

endmodule

/* logic/read_burst_gather.sv */
module read_burst_gather
  import line_mem_pkg::*;
#(
  parameter int line_bytes = 64
) (
  input  logic                     sclk,
  input  logic                     rst,
  input  logic                     gather_start,
  input  logic                     app_rd_data_valid,
  input  logic [app_data_bits-1:0] app_rd_data,
  output logic                     gather_busy,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output logic [line_bytes*8-1:0]  resp_data
);

  localparam int num_bursts = line_bytes / burst_bytes;
  localparam int cnt_bits   = (num_bursts > 1) ? $clog2(num_bursts) : 1;

  logic [cnt_bits-1:0]    burst_cnt;
  // assembled line, also the response payload
  logic [line_bytes*8-1:0] line_q;

  assign resp_data = line_q;

  always_ff @(posedge sclk) begin
    if (rst) begin
      gather_busy <= 1'b0;
      resp_valid  <= 1'b0;
      burst_cnt   <= '0;
    end else begin
      if (gather_start) begin
        gather_busy <= 1'b1;
        burst_cnt   <= '0;
      end else if (app_rd_data_valid) begin
        // last burst in, response goes out next clock
        if (burst_cnt == cnt_bits'(num_bursts - 1)) begin
          resp_valid <= 1'b1;
          burst_cnt  <= '0;
        end else begin
          burst_cnt <= burst_cnt + 1'b1;
        end
      end
      if (resp_valid && resp_ready) begin
        resp_valid  <= 1'b0;
        gather_busy <= 1'b0;
      end
    end
  end

  // slice k of the line from burst k
  always_ff @(posedge sclk) begin
    if (app_rd_data_valid) begin
      line_q[burst_cnt*app_data_bits +: app_data_bits] <= app_rd_data;
    end
  end

  // controller only returns data for commands dispatch has issued
  a_data_when_busy : assert property (@(posedge sclk) disable iff (rst)
    app_rd_data_valid |-> gather_busy && !resp_valid);

endmodule

/* logic/dram_line_port.sv */
module dram_line_port
  import line_mem_pkg::*;
#(
  parameter int line_bytes  = 64,
  parameter int queue_depth = 4
) (
  input  logic                     sclk,
  input  logic                     rst,
  // cache write channel
  input  logic                     wr_valid,
  output logic                     wr_ready,
  input  logic [app_addr_bits-1:0] wr_addr,
  input  logic [line_bytes*8-1:0]  wr_data,
  // cache read channel
  input  logic                     rd_valid,
  output logic                     rd_ready,
  input  logic [app_addr_bits-1:0] rd_addr,
  // read response
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output logic [line_bytes*8-1:0]  resp_data,
  // controller application port
  output logic                     app_en,
  output app_cmd_e                 app_cmd,
  output logic [app_addr_bits-1:0] app_addr,
  output logic                     app_wdf_wren,
  output logic                     app_wdf_end,
  output logic [app_data_bits-1:0] app_wdf_data,
  input  logic                     app_rdy,
  input  logic                     app_wdf_rdy,
  input  logic                     app_rd_data_valid,
  input  logic [app_data_bits-1:0] app_rd_data
);

  logic gather_start;
  logic gather_busy;

  // intake to queue, queue to dispatch
  line_req_if #(.line_bytes(line_bytes)) in_req ();
  line_req_if #(.line_bytes(line_bytes)) q_req ();

  line_request_intake #(.line_bytes(line_bytes)) u_intake (
    .sclk     (sclk),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready),
    .rd_addr  (rd_addr),
    .req      (in_req.producer)
  );

  line_request_queue #(
    .line_bytes  (line_bytes),
    .queue_depth (queue_depth)
  ) u_queue (
    .sclk (sclk),
    .rst  (rst),
    .push (in_req.consumer),
    .pop  (q_req.producer)
  );

  burst_dispatch #(.line_bytes(line_bytes)) u_dispatch (
    .sclk         (sclk),
    .rst          (rst),
    .req          (q_req.consumer),
    .app_en       (app_en),
    .app_cmd      (app_cmd),
    .app_addr     (app_addr),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .app_wdf_data (app_wdf_data),
    .app_rdy      (app_rdy),
    .app_wdf_rdy  (app_wdf_rdy),
    .gather_busy  (gather_busy),
    .gather_start (gather_start)
  );

  read_burst_gather #(.line_bytes(line_bytes)) u_gather (
    .sclk              (sclk),
    .rst               (rst),
    .gather_start      (gather_start),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data),
    .gather_busy       (gather_busy),
    .resp_valid        (resp_valid),
    .resp_ready        (resp_ready),
    .resp_data         (resp_data)
  );

endmodule

/* tb/app_port_model.sv */
module app_port_model
  import line_mem_pkg::*;
#(
  parameter int line_bytes = 64
) (
  input  logic                     sclk,
  input  logic                     rst,
  // random stalls on both readies
  input  logic                     stall_en,
  // app_rdy held low while set
  input  logic                     cmd_block,
  // per-cycle random bits from the testbench
  input  logic [31:0]              noise,
  input  logic                     app_en,
  input  app_cmd_e                 app_cmd,
  input  logic [app_addr_bits-1:0] app_addr,
  input  logic                     app_wdf_wren,
  input  logic                     app_wdf_end,
  input  logic [app_data_bits-1:0] app_wdf_data,
  output logic                     app_rdy,
  output logic                     app_wdf_rdy,
  output logic                     app_rd_data_valid,
  output logic [app_data_bits-1:0] app_rd_data,
  output int                       errors
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_bursts = line_bytes / burst_bytes;

  // sparse memory keyed by burst address
  logic [app_data_bits-1:0] mem [int];
  // read bursts in flight in command order with the cycle each is due
  logic [app_data_bits-1:0] rd_q [$];
  int                       due_q [$];
  int                       cycle;
  int                       last_due;
  int                       burst_k;
  logic [app_addr_bits-1:0] line_base;
  logic                     nxt_rdy;
  logic                     nxt_wdf_rdy;
  logic                     nxt_valid;
  logic [app_data_bits-1:0] nxt_data;

  // never written bursts read back as a pattern of their own address
  function automatic logic [app_data_bits-1:0] fill_burst(input logic [app_addr_bits-1:0] a);
    return {4{32'h5a00_0000 ^ 32'(a)}};
  endfunction

  task automatic take_command();
    logic [app_addr_bits-1:0] exp_addr;
    int                       lat;
    if (burst_k == 0) begin
      line_base = app_addr;
    end
    exp_addr = line_base + app_addr_bits'(burst_k * burst_bytes);
    lat      = 2 + int'(noise[10:8]) % 7;
    assert (line_base % line_bytes == 0) else begin
      errors++;
      $display("Error at %0t ns: line address %h is not aligned to a line", $time, line_base);
    end
    assert (app_addr == exp_addr) else begin
      errors++;
      $display("Mismatch at %0t ns: app_addr expected %h, got %h", $time, exp_addr, app_addr);
    end
    if (app_cmd == app_cmd_write) begin
      assert (app_wdf_wren && app_wdf_end) else begin
        errors++;
        $display("Error at %0t ns: write command taken without its data beat", $time);
      end
      mem[int'(app_addr)] = app_wdf_data;
    end else begin
      rd_q.push_back(mem.exists(int'(app_addr)) ? mem[int'(app_addr)] : fill_burst(app_addr));
      // in order and at most one burst per cycle
      last_due = (cycle + lat > last_due) ? cycle + lat : last_due + 1;
      due_q.push_back(last_due);
    end
    burst_k = (burst_k == num_bursts - 1) ? 0 : burst_k + 1;
  endtask

  initial begin
    app_rdy           = 1'b0;
    app_wdf_rdy       = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data       = '0;
    nxt_data          = '0;
    errors            = 0;
    cycle             = 0;
    last_due          = 0;
    burst_k           = 0;
    forever begin
      // inputs settled here and the handshake lands on the coming edge
      @(negedge sclk);
      cycle++;
      if (!rst && app_en && app_rdy && (app_cmd != app_cmd_write || app_wdf_rdy)) begin
        take_command();
      end
      nxt_rdy     = !rst && !cmd_block && !(stall_en && noise[1:0] == 2'b00);
      nxt_wdf_rdy = !rst && !(stall_en && noise[3:2] == 2'b00);
      nxt_valid   = 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        nxt_data  = rd_q.pop_front();
        nxt_valid = 1'b1;
      end
      @(posedge sclk);
      #2;
      app_rdy           = nxt_rdy;
      app_wdf_rdy       = nxt_wdf_rdy;
      app_rd_data_valid = nxt_valid;
      app_rd_data       = nxt_data;
    end
  end

endmodule

/* tb/tb_dram_line_port.sv */
module tb_dram_line_port
  import line_mem_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int line_bytes  = 64;
  localparam int queue_depth = 4;
  localparam int line_bits   = line_bytes * 8;
  localparam int num_bursts  = line_bytes / burst_bytes;
  // requests over all six tests at 40 cycles each plus margin
  localparam int total_reqs     = 45;
  localparam int timeout_cycles = total_reqs * 40 + 500;

  logic                     sclk;
  logic                     rst;
  logic                     wr_valid;
  logic                     wr_ready;
  logic [app_addr_bits-1:0] wr_addr;
  logic [line_bits-1:0]     wr_data;
  logic                     rd_valid;
  logic                     rd_ready;
  logic [app_addr_bits-1:0] rd_addr;
  logic                     resp_valid;
  logic                     resp_ready;
  logic [line_bits-1:0]     resp_data;
  logic                     app_en;
  app_cmd_e                 app_cmd;
  logic [app_addr_bits-1:0] app_addr;
  logic                     app_wdf_wren;
  logic                     app_wdf_end;
  logic [app_data_bits-1:0] app_wdf_data;
  logic                     app_rdy;
  logic                     app_wdf_rdy;
  logic                     app_rd_data_valid;
  logic [app_data_bits-1:0] app_rd_data;
  logic                     stall_en;
  logic                     cmd_block;
  logic [31:0]              noise;
  int                       model_errors;

  // reference memory updated in order as writes are accepted
  logic [line_bits-1:0] ref_mem [int];
  // expected responses in read order
  logic [line_bits-1:0] exp_q [$];
  int                   errors = 0;
  int                   checks = 0;
  int                   tests  = 0;
  int                   mark   = 0;
  int                   cycles = 0;
  logic                 held_stall;
  logic [line_bits-1:0] held_data;

  dram_line_port #(
    .line_bytes  (line_bytes),
    .queue_depth (queue_depth)
  ) u_dut (
    .sclk (sclk), .rst (rst),
    .wr_valid (wr_valid), .wr_ready (wr_ready), .wr_addr (wr_addr), .wr_data (wr_data),
    .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_addr (rd_addr),
    .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_data (resp_data),
    .app_en (app_en), .app_cmd (app_cmd), .app_addr (app_addr),
    .app_wdf_wren (app_wdf_wren), .app_wdf_end (app_wdf_end), .app_wdf_data (app_wdf_data),
    .app_rdy (app_rdy), .app_wdf_rdy (app_wdf_rdy),
    .app_rd_data_valid (app_rd_data_valid), .app_rd_data (app_rd_data)
  );

  app_port_model #(.line_bytes(line_bytes)) u_mem (
    .sclk (sclk), .rst (rst), .stall_en (stall_en), .cmd_block (cmd_block), .noise (noise),
    .app_en (app_en), .app_cmd (app_cmd), .app_addr (app_addr),
    .app_wdf_wren (app_wdf_wren), .app_wdf_end (app_wdf_end), .app_wdf_data (app_wdf_data),
    .app_rdy (app_rdy), .app_wdf_rdy (app_wdf_rdy),
    .app_rd_data_valid (app_rd_data_valid), .app_rd_data (app_rd_data),
    .errors (model_errors)
  );

  initial begin
    sclk = 1'b0;
    forever #10 sclk = ~sclk;
  end

  // watchdog
  always @(posedge sclk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: run still going after %0d cycles", timeout_cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [app_addr_bits-1:0] line_addr(input int idx);
    return app_addr_bits'(32'h0012_3400 + idx * line_bytes);
  endfunction

  function automatic logic [line_bits-1:0] rand_line();
    logic [line_bits-1:0] v;
    for (int i = 0; i < line_bits / 32; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  // unwritten lines come back as the model's per-burst address pattern
  function automatic logic [line_bits-1:0] expected_line(input logic [app_addr_bits-1:0] addr);
    logic [line_bits-1:0] v;
    logic [31:0]          word;
    if (ref_mem.exists(int'(addr))) begin
      return ref_mem[int'(addr)];
    end
    for (int k = 0; k < num_bursts; k++) begin
      word = 32'h5a00_0000 ^ 32'(addr + app_addr_bits'(k * burst_bytes));
      v[k*app_data_bits +: app_data_bits] = {4{word}};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [line_bits-1:0] expected,
                             input logic [line_bits-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic next_cycle();
    @(posedge sclk);
    #2;
  endtask

  task automatic send_write(input logic [app_addr_bits-1:0] addr,
                            input logic [line_bits-1:0] data);
    wr_valid = 1'b1;
    wr_addr  = addr;
    wr_data  = data;
    do begin
      @(negedge sclk);
    end while (!wr_ready);
    // taken on the coming edge
    ref_mem[int'(addr)] = data;
    next_cycle();
    wr_valid = 1'b0;
  endtask

  task automatic send_read(input logic [app_addr_bits-1:0] addr);
    rd_valid = 1'b1;
    rd_addr  = addr;
    do begin
      @(negedge sclk);
    end while (!rd_ready);
    exp_q.push_back(expected_line(addr));
    next_cycle();
    rd_valid = 1'b0;
  endtask

  // write and read of one line offered in the same cycle
  task automatic send_tie(input logic [app_addr_bits-1:0] addr,
                          input logic [line_bits-1:0] data);
    wr_valid = 1'b1;
    wr_addr  = addr;
    wr_data  = data;
    rd_valid = 1'b1;
    rd_addr  = addr;
    do begin
      @(negedge sclk);
      check_true(!rd_ready, "read accepted ahead of the write it tied with");
    end while (!wr_ready);
    ref_mem[int'(addr)] = data;
    next_cycle();
    wr_valid = 1'b0;
    do begin
      @(negedge sclk);
    end while (!rd_ready);
    exp_q.push_back(expected_line(addr));
    next_cycle();
    rd_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();
  endtask

  // bursts of one line as stored in the model
  task automatic check_model_line(input logic [app_addr_bits-1:0] addr,
                                  input logic [line_bits-1:0] data);
    int key;
    for (int k = 0; k < num_bursts; k++) begin
      key = int'(addr) + k * burst_bytes;
      check_true(u_mem.mem.exists(key), $sformatf("burst at %h never reached the model", key));
      if (u_mem.mem.exists(key)) begin
        check_value($sformatf("u_mem.mem[%h]", key),
                    line_bits'(data[k*app_data_bits +: app_data_bits]),
                    line_bits'(u_mem.mem[key]));
      end
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors + model_errors - mark);
    mark = errors + model_errors;
  endtask

  // response monitor sampled at the falling edge
  initial begin
    held_stall = 1'b0;
    held_data  = '0;
    forever begin
      @(negedge sclk);
      if (held_stall) begin
        check_true(resp_valid, "resp_valid dropped while resp_ready was low");
        check_value("resp_data", held_data, resp_data);
      end
      held_stall = resp_valid && !resp_ready;
      held_data  = resp_data;
      if (resp_valid && resp_ready) begin
        check_true(exp_q.size() != 0, "read response with no read outstanding");
        if (exp_q.size() != 0) begin
          check_value("resp_data", exp_q.pop_front(), resp_data);
        end
      end
    end
  end

  initial begin
    logic [app_addr_bits-1:0] addr;
    logic [line_bits-1:0]     data;
    logic [line_bits-1:0]     data_b;
    logic [app_addr_bits-1:0] held_addrs [$];
    int                       accepted;
    int                       blocked;
    void'($urandom(32'h83a2));
    rst        = 1'b1;
    wr_valid   = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_valid   = 1'b0;
    rd_addr    = '0;
    resp_ready = 1'b1;
    stall_en   = 1'b0;
    cmd_block  = 1'b0;
    noise      = '0;
    fork
      forever begin
        next_cycle();
        noise = $urandom;
      end
    join_none

    // two reset cycles with outputs quiet in reset and the clock after
    @(posedge sclk);
    @(negedge sclk);
    check_true(!wr_ready && !rd_ready && !resp_valid && !app_en && !app_wdf_wren,
               "control outputs not low in reset");
    next_cycle();
    rst = 1'b0;
    @(negedge sclk);
    check_true(!wr_ready && !rd_ready && !resp_valid && !app_en && !app_wdf_wren,
               "control outputs not low in the first clock after reset");
    next_cycle();

    // unwritten line first and then a write and read back
    addr = line_addr(20);
    send_read(addr);
    send_write(addr, rand_line());
    send_read(addr);
    drain();
    end_test("write_then_read");

    // last line of the address space too
    held_addrs = {line_addr(1), line_addr(9), app_addr_bits'(27'h7ff_ffc0)};
    foreach (held_addrs[i]) begin
      send_write(held_addrs[i], rand_line());
    end
    send_read(held_addrs[0]);
    drain();
    foreach (held_addrs[i]) begin
      check_model_line(held_addrs[i], ref_mem[int'(held_addrs[i])]);
    end
    end_test("burst_addressing");

    stall_en = 1'b1;
    for (int i = 0; i < 20; i++) begin
      addr = line_addr($urandom_range(0, 7));
      if ($urandom_range(0, 1) == 0 || !ref_mem.exists(int'(addr))) begin
        send_write(addr, rand_line());
      end else begin
        send_read(addr);
      end
    end
    drain();
    stall_en = 1'b0;
    end_test("controller_stalls");

    send_tie(line_addr(21), rand_line());
    drain();
    end_test("tie_same_line");

    // writes behind a held-off response still go out
    addr = line_addr(22);
    send_write(addr, rand_line());
    resp_ready = 1'b0;
    send_read(addr);
    while (!resp_valid) begin
      next_cycle();
    end
    data   = rand_line();
    data_b = rand_line();
    send_write(line_addr(23), data);
    send_write(line_addr(24), data_b);
    // last burst of the second write reaches the model
    while (!u_mem.mem.exists(int'(line_addr(24)) + (num_bursts - 1) * burst_bytes)) begin
      next_cycle();
    end
    check_model_line(line_addr(23), data);
    check_model_line(line_addr(24), data_b);
    resp_ready = 1'b1;
    drain();
    end_test("response_backpressure");

    // fill the queue against a blocked controller until wr_ready stays low
    cmd_block = 1'b1;
    repeat (2) next_cycle();
    held_addrs = {};
    accepted   = 0;
    blocked    = 0;
    wr_valid   = 1'b1;
    wr_addr    = line_addr(30);
    wr_data    = rand_line();
    while (blocked < 10) begin
      @(negedge sclk);
      if (wr_ready) begin
        ref_mem[int'(wr_addr)] = wr_data;
        held_addrs.push_back(wr_addr);
        accepted++;
        blocked = 0;
        next_cycle();
        wr_addr = line_addr(30 + accepted);
        wr_data = rand_line();
      end else begin
        blocked++;
        next_cycle();
      end
    end
    check_true(accepted <= queue_depth + 1,
               $sformatf("%0d requests accepted with the controller blocked", accepted));
    cmd_block = 1'b0;
    do begin
      @(negedge sclk);
    end while (!wr_ready);
    ref_mem[int'(wr_addr)] = wr_data;
    held_addrs.push_back(wr_addr);
    next_cycle();
    wr_valid = 1'b0;
    foreach (held_addrs[i]) begin
      send_read(held_addrs[i]);
    end
    drain();
    end_test("full_queue");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + model_errors);
    if (errors + model_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sources.f */
logic/line_mem_pkg.sv
logic/line_req_if.sv
logic/line_request_intake.sv
logic/line_request_queue.sv
logic/burst_dispatch.sv
logic/read_burst_gather.sv
logic/dram_line_port.sv
tb/app_port_model.sv
tb/tb_dram_line_port.sv

/* Bender.yml */
package:
  name: dram_line_port

sources:
  - logic/line_mem_pkg.sv
  - logic/line_req_if.sv
  - logic/line_request_intake.sv
  - logic/line_request_queue.sv
  - logic/burst_dispatch.sv
  - logic/read_burst_gather.sv
  - logic/dram_line_port.sv
  - target: test
    files:
      - tb/app_port_model.sv
      - tb/tb_dram_line_port.sv
